//--- source/flash_rom_pkg.sv
package flash_rom_pkg;

  // CPU byte address is 17 bits inside a bank plus the bank bit
  parameter int CPU_ADDR_W = 18;

  // word address pins of one NOR flash part
  parameter int FLASH_A_W = 21;

  // one registered request
  typedef struct packed {
    logic [15:0] word_addr;  // byte address within bank >> 1
    logic        a0;         // odd byte
    logic        byte_m;     // byte access
  } rom_req_t;

  // pins driven by one bank reader
  typedef struct packed {
    logic                 ce_n;
    logic                 oe_n;
    logic [FLASH_A_W-1:0] a;
  } flash_pins_t;

  // raw words fetched from one bank
  typedef struct packed {
    logic [15:0] word0;
    logic [15:0] word1;  // only valid for odd word reads
  } bank_resp_t;

endpackage

//--- source/rom_req_decoder.sv
`timescale 1ns/10ps

module rom_req_decoder #(
  parameter int NUM_BANKS = 2
) (
  input  logic                                   cpu_clk,
  input  logic                                   reset,
  input  logic                                   req,
  input  logic [flash_rom_pkg::CPU_ADDR_W-1:0]   addr,
  input  logic                                   byte_m,
  input  logic                                   rd_valid,
  output logic                                   ready,
  output logic [NUM_BANKS-1:0]                   start,
  output flash_rom_pkg::rom_req_t                cur_req,
  output logic [$clog2(NUM_BANKS)-1:0]           cur_bank
);

  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int IN_W   = flash_rom_pkg::CPU_ADDR_W - BANK_W;

  logic              busy;
  logic              accept;
  logic [BANK_W-1:0] bank;
  logic [IN_W-1:0]   in_bank_addr;

  // ready comes back in the same cycle as rd_valid
  assign ready  = !busy || rd_valid;
  assign accept = req && ready;

  assign bank         = addr[flash_rom_pkg::CPU_ADDR_W-1 -: BANK_W];
  assign in_bank_addr = addr[IN_W-1:0];  // address within the bank

  always_ff @(posedge cpu_clk)
  begin
    if (reset)
    begin
      busy  <= 1'b0;
      start <= '0;
    end
    else
    begin
      start <= accept ? (NUM_BANKS'(1) << bank) : '0;
      if (accept)
        busy <= 1'b1;  // new request wins over rd_valid
      else if (rd_valid)
        busy <= 1'b0;
    end
  end

  always_ff @(posedge cpu_clk)
  begin
    if (accept)
    begin
      cur_req.word_addr <= in_bank_addr[16:1];
      cur_req.a0        <= in_bank_addr[0];
      cur_req.byte_m    <= byte_m;
      cur_bank          <= bank;
    end
  end

  // every result answers a pending request
  a_valid_busy: assert property (@(posedge cpu_clk) disable iff (reset) rd_valid |-> busy);

endmodule

//--- source/flash_bank_reader.sv
`timescale 1ns/10ps

module flash_bank_reader #(
  parameter int WAIT_STATES = 3
) (
  input  logic                       cpu_clk,
  input  logic                       reset,
  input  logic                       start,
  input  flash_rom_pkg::rom_req_t    cur_req,
  input  logic [15:0]                flash_d,
  output flash_rom_pkg::flash_pins_t flash_pins,
  output flash_rom_pkg::bank_resp_t  resp,
  output logic                       done
);

  localparam int CNT_W = $clog2(WAIT_STATES + 1);
  localparam int PAD_W = flash_rom_pkg::FLASH_A_W - 16;

  typedef enum logic [1:0] {
    st_idle,
    st_wait0,   // address of word0 on the pins
    st_wait1,   // address of word1 on the pins
    st_finish
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] wait_cnt;
  logic [15:0]      word_addr_q;
  logic             two_word;
  logic             cnt_zero;
  logic             launch;

  assign launch   = (state == st_idle) && start;
  assign cnt_zero = (wait_cnt == '0);
  assign done     = (state == st_finish);  // one cycle after the last capture

  always_ff @(posedge cpu_clk)
  begin
    if (reset)
    begin
      state           <= st_idle;
      wait_cnt        <= '0;
      two_word        <= 1'b0;
      flash_pins.ce_n <= 1'b1;
      flash_pins.oe_n <= 1'b1;
      flash_pins.a    <= '0;
    end
    else
    begin
      case (state)
        st_idle:
          if (start)
          begin
            state           <= st_wait0;
            wait_cnt        <= CNT_W'(WAIT_STATES);
            two_word        <= !cur_req.byte_m && cur_req.a0;
            flash_pins.ce_n <= 1'b0;
            flash_pins.oe_n <= 1'b0;
            flash_pins.a    <= {{PAD_W{1'b0}}, cur_req.word_addr};
          end

        st_wait0:
          if (!cnt_zero)
            wait_cnt <= wait_cnt - CNT_W'(1);
          else if (two_word)
          begin
            // next word wraps inside the bank
            state        <= st_wait1;
            wait_cnt     <= CNT_W'(WAIT_STATES);
            flash_pins.a <= {{PAD_W{1'b0}}, word_addr_q + 16'd1};
          end
          else
          begin
            state           <= st_finish;
            flash_pins.ce_n <= 1'b1;
            flash_pins.oe_n <= 1'b1;
          end

        st_wait1:
          if (!cnt_zero)
            wait_cnt <= wait_cnt - CNT_W'(1);
          else
          begin
            state           <= st_finish;
            flash_pins.ce_n <= 1'b1;
            flash_pins.oe_n <= 1'b1;
          end

        default:
          state <= st_idle;
      endcase
    end
  end

  // flash data capture
  always_ff @(posedge cpu_clk)
  begin
    if (launch)
      word_addr_q <= cur_req.word_addr;
    if (state == st_wait0 && cnt_zero)
      resp.word0 <= flash_d;
    if (state == st_wait1 && cnt_zero)
      resp.word1 <= flash_d;
  end

  // decoder must hold off until this bank has finished
  a_start_idle: assert property (
    @(posedge cpu_clk) disable iff (reset) start |-> state == st_idle
  );

endmodule

//--- source/rom_resp_collector.sv
`timescale 1ns/10ps

module rom_resp_collector #(
  parameter int NUM_BANKS = 2
) (
  input  logic                                      cpu_clk,
  input  logic                                      reset,
  input  logic [NUM_BANKS-1:0]                      done,
  input  flash_rom_pkg::bank_resp_t [NUM_BANKS-1:0] resp,
  input  flash_rom_pkg::rom_req_t                   cur_req,
  input  logic [$clog2(NUM_BANKS)-1:0]              cur_bank,
  output logic [15:0]                               rd_data,
  output logic                                      rd_valid
);

  logic                      any_done;
  flash_rom_pkg::bank_resp_t sel;
  logic [7:0]                byte_pick;
  logic [15:0]               data_d;

  assign any_done  = |done;
  assign sel       = resp[cur_bank];
  assign byte_pick = cur_req.a0 ? sel.word0[15:8] : sel.word0[7:0];

  always_comb
  begin
    if (cur_req.byte_m)
      data_d = {{8{byte_pick[7]}}, byte_pick};  // sign extend
    else if (cur_req.a0)
      data_d = {sel.word1[7:0], sel.word0[15:8]};  // straddles two flash words
    else
      data_d = sel.word0;
  end

  always_ff @(posedge cpu_clk)
  begin
    if (reset)
      rd_valid <= 1'b0;
    else
      rd_valid <= any_done;
  end

  // held until the next result
  always_ff @(posedge cpu_clk)
  begin
    if (any_done)
      rd_data <= data_d;
  end

  a_done_bank: assert property (
    @(posedge cpu_clk) disable iff (reset)
    any_done |-> done == (NUM_BANKS'(1) << cur_bank)
  );

endmodule

//--- source/flash_rom_top.sv
`timescale 1ns/10ps

module flash_rom_top #(
  parameter int NUM_BANKS   = 2,
  parameter int WAIT_STATES = 3
) (
  input  logic                                       cpu_clk,
  input  logic                                       reset,
  input  logic                                       req,
  input  logic [flash_rom_pkg::CPU_ADDR_W-1:0]       addr,
  input  logic                                       byte_m,
  output logic                                       ready,
  output logic [15:0]                                rd_data,
  output logic                                       rd_valid,
  output flash_rom_pkg::flash_pins_t [NUM_BANKS-1:0] flash_pins,
  input  logic [NUM_BANKS-1:0][15:0]                 flash_d
);

  logic [NUM_BANKS-1:0]                      start;
  logic [NUM_BANKS-1:0]                      done;
  logic [$clog2(NUM_BANKS)-1:0]              cur_bank;
  flash_rom_pkg::rom_req_t                   cur_req;
  flash_rom_pkg::bank_resp_t [NUM_BANKS-1:0] resp;

  rom_req_decoder #(.NUM_BANKS(NUM_BANKS)) rom_req_decoder_i (
    .cpu_clk  (cpu_clk),
    .reset    (reset),
    .req      (req),
    .addr     (addr),
    .byte_m   (byte_m),
    .rd_valid (rd_valid),
    .ready    (ready),
    .start    (start),
    .cur_req  (cur_req),
    .cur_bank (cur_bank)
  );

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    flash_bank_reader #(.WAIT_STATES(WAIT_STATES)) flash_bank_reader_i (
      .cpu_clk    (cpu_clk),
      .reset      (reset),
      .start      (start[b]),
      .cur_req    (cur_req),
      .flash_d    (flash_d[b]),
      .flash_pins (flash_pins[b]),
      .resp       (resp[b]),
      .done       (done[b])
    );
  end

  rom_resp_collector #(.NUM_BANKS(NUM_BANKS)) rom_resp_collector_i (
    .cpu_clk  (cpu_clk),
    .reset    (reset),
    .done     (done),
    .resp     (resp),
    .cur_req  (cur_req),
    .cur_bank (cur_bank),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

endmodule

//--- test/flash_prom_model.sv
`timescale 1ns/10ps

module flash_prom_model #(
  parameter int BANK = 0
) (
  input  flash_rom_pkg::flash_pins_t pins,
  output logic [15:0]                d
);

  logic [15:0] w;

  assign w = pins.a[15:0];

  // bus floats high unless selected and output enabled
  assign d = (!pins.ce_n && !pins.oe_n) ? (w ^ 16'h5a3c) + 16'(BANK) * 16'h1111 : 16'hffff;

endmodule

//--- test/flash_rom_tb.sv
`timescale 1ns/10ps

module flash_rom_tb;

  localparam int NUM_BANKS   = 2;
  localparam int WAIT_STATES = 3;
  localparam int LAT_SINGLE  = WAIT_STATES + 3;
  localparam int LAT_DOUBLE  = 2 * WAIT_STATES + 4;
  localparam int TIMEOUT     = 50;

  logic                                       cpu_clk;
  logic                                       reset;
  logic                                       req;
  logic [flash_rom_pkg::CPU_ADDR_W-1:0]       addr;
  logic                                       byte_m;
  logic                                       ready;
  logic [15:0]                                rd_data;
  logic                                       rd_valid;
  flash_rom_pkg::flash_pins_t [NUM_BANKS-1:0] flash_pins;
  logic [NUM_BANKS-1:0][15:0]                 flash_d;

  int errors;
  int checks;

  flash_rom_top #(.NUM_BANKS(NUM_BANKS), .WAIT_STATES(WAIT_STATES)) flash_rom_top_i (
    .cpu_clk    (cpu_clk),
    .reset      (reset),
    .req        (req),
    .addr       (addr),
    .byte_m     (byte_m),
    .ready      (ready),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .flash_pins (flash_pins),
    .flash_d    (flash_d)
  );

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_prom
    flash_prom_model #(.BANK(b)) flash_prom_model_i (
      .pins (flash_pins[b]),
      .d    (flash_d[b])
    );
  end

  always #4 cpu_clk = ~cpu_clk;

  function automatic logic [15:0] prom_word(input int bank, input logic [15:0] w);
    return (w ^ 16'h5a3c) + 16'(bank) * 16'h1111;
  endfunction

  function automatic logic [15:0] expected_read(input logic [17:0] a, input logic is_byte);
    logic [15:0] w0;
    logic [15:0] w1;
    logic [7:0]  pick;
    w0   = prom_word(int'(a[17]), a[16:1]);
    w1   = prom_word(int'(a[17]), a[16:1] + 16'd1);  // wraps inside the bank
    pick = a[0] ? w0[15:8] : w0[7:0];
    if (is_byte)
      return {{8{pick[7]}}, pick};
    else if (a[0])
      return {w1[7:0], w0[15:8]};
    return w0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // called 1 ns after a rising edge
  task automatic read_and_check(input logic [17:0] a, input logic is_byte, input logic stray);
    int          cycles;
    int          exp_lat;
    logic [15:0] exp_data;
    exp_lat  = (!is_byte && a[0]) ? LAT_DOUBLE : LAT_SINGLE;
    exp_data = expected_read(a, is_byte);
    cycles   = 0;
    while (!ready && cycles < TIMEOUT)
    begin
      @(posedge cpu_clk);
      #1;
      cycles++;
    end
    if (!ready)
    begin
      errors++;
      $display("ready stayed low, request to address %h not issued", a);
      return;
    end
    req    = 1'b1;
    addr   = a;
    byte_m = is_byte;
    @(posedge cpu_clk);  // accepting edge
    #1;
    req    = 1'b0;
    cycles = 0;
    while (!rd_valid && cycles < TIMEOUT)
    begin
      check_value("ready", 0, ready);
      if (stray && cycles == 2)
      begin
        req    = 1'b1;  // dropped since ready is low
        addr   = ~a;
        byte_m = ~is_byte;
      end
      @(posedge cpu_clk);
      #1;
      req = 1'b0;
      cycles++;
    end
    if (!rd_valid)
    begin
      errors++;
      $display("no rd_valid within %0d cycles for address %h", TIMEOUT, a);
      return;
    end
    check_value("latency", exp_lat, cycles);
    check_value("ready", 1, ready);
    check_value("rd_data", exp_data, rd_data);
  endtask

  task automatic check_idle(input int n);
    logic [15:0] held;
    held = rd_data;
    repeat (n)
    begin
      @(posedge cpu_clk);
      #1;
      check_value("rd_valid", 0, rd_valid);
      check_value("ready", 1, ready);
      check_value("rd_data", held, rd_data);
    end
  endtask

  task automatic verify_reset_state();
    check_value("ready", 1, ready);
    check_value("rd_valid", 0, rd_valid);
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      check_value("flash_pins.ce_n", 1, flash_pins[b].ce_n);
      check_value("flash_pins.oe_n", 1, flash_pins[b].oe_n);
      check_value("flash_pins.a", 0, flash_pins[b].a);
    end
  endtask

  task automatic read_aligned_words();
    for (int i = 0; i < 8; i++)
      read_and_check({i[0], 16'($urandom()), 1'b0}, 1'b0, 1'b0);
  endtask

  task automatic read_sign_extended_bytes();
    for (int i = 0; i < 8; i++)
      read_and_check({1'($urandom()), 16'($urandom()), i[0]}, 1'b1, 1'b0);
    read_and_check(18'h00180, 1'b1, 1'b0);  // low byte fc
    read_and_check(18'h10001, 1'b1, 1'b0);  // high byte da
    read_and_check(18'h3fffe, 1'b1, 1'b0);  // low byte d4 in bank 1
    read_and_check(18'h20001, 1'b1, 1'b0);
  endtask

  task automatic read_odd_words();
    for (int i = 0; i < 6; i++)
      read_and_check({i[0], 16'($urandom()), 1'b1}, 1'b0, 1'b0);
    read_and_check(18'h1ffff, 1'b0, 1'b0);  // last word wraps to word 0
    read_and_check(18'h3ffff, 1'b0, 1'b0);
  endtask

  task automatic ignore_busy_req();
    read_and_check({1'b0, 16'($urandom()), 1'b0}, 1'b0, 1'b1);
    check_idle(LAT_DOUBLE + 2);
    read_and_check({1'b1, 16'($urandom()), 1'b1}, 1'b0, 1'b1);
    check_idle(LAT_DOUBLE + 2);
  endtask

  initial
  begin
    int unsigned seed;
    seed    = 32'hce70faf3;
    void'($urandom(seed));
    errors  = 0;
    checks  = 0;
    cpu_clk = 1'b0;
    reset   = 1'b1;
    req     = 1'b0;
    addr    = '0;
    byte_m  = 1'b0;
    repeat (3) @(posedge cpu_clk);
    #1;
    verify_reset_state();
    reset = 1'b0;
    check_idle(2);
    read_aligned_words();
    read_sign_extended_bytes();
    read_odd_words();
    ignore_busy_req();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- vlog.f
source/flash_rom_pkg.sv
source/rom_req_decoder.sv
source/flash_bank_reader.sv
source/rom_resp_collector.sv
source/flash_rom_top.sv
test/flash_prom_model.sv
test/flash_rom_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the flash ROM testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module flash_rom_tb -o flash_rom_sim -f vlog.f \
  && ./obj_dir/flash_rom_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
